// File: build.f
sparse_mul_pkg.sv
sdp_ram.sv
sparse_mul_ctrl.sv
sparse_mul_core.sv
sparse_mul_accum.sv
sparse_mul_top.sv
tb_sparse_mul.sv

// File: sdp_ram.sv
// --------------------------------------------------
// simple dual-port RAM with one write port and
// a registered read port
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  payload_t                 wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output payload_t                 rd_data
);

  payload_t mem [DEPTH];

  // write port
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read data shows up one cycle after the address
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: sparse_mul_accum.sv
// --------------------------------------------------
// lane adder tree, mod Q reduction and accumulation
// into the result RAM, plus host readback
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sparse_mul_accum (
  input  logic                              clk,
  input  logic                              rst,
  input  sparse_mul_pkg::step_t             step,
  input  sparse_mul_pkg::coeff_pair_t       lanes [sparse_mul_pkg::NUM_CORES],
  input  logic                              rd_en,
  input  logic [sparse_mul_pkg::STEP_W-1:0] rd_addr,
  output logic                              wr_last,
  output sparse_mul_pkg::coeff_pair_t       rd_data
);
  import sparse_mul_pkg::*;

  // 256 = 5 mod 251, so the bits above the low byte count five each
  function automatic logic [COEFF_W:0] fold(input logic [SUM_W-1:0] s);
    logic [COEFF_W:0] hi;
    hi = (COEFF_W + 1)'(s[SUM_W-1:COEFF_W]);
    return (hi << 2) + hi + (COEFF_W + 1)'(s[COEFF_W-1:0]);
  endfunction

  function automatic coeff_t sub_q(input logic [COEFF_W:0] x);
    return (x >= Q) ? coeff_t'(int'(x) - Q) : coeff_t'(x);
  endfunction

  step_t             pipe [4];
  logic [SUM_W-1:0]  sum_lo;
  logic [SUM_W-1:0]  sum_hi;
  logic [SUM_W-1:0]  sum_q_lo;
  logic [SUM_W-1:0]  sum_q_hi;
  logic [COEFF_W:0]  fold_q_lo;
  logic [COEFF_W:0]  fold_q_hi;
  coeff_pair_t       red_q;
  coeff_pair_t       prev;
  logic [COEFF_W:0]  acc_lo;
  logic [COEFF_W:0]  acc_hi;
  logic              wr_en_q;
  logic [STEP_W-1:0] wr_addr_q;
  coeff_pair_t       wr_data_q;
  logic [STEP_W-1:0] ram_rd_addr;
  coeff_pair_t       ram_q;

  // step control follows the data through 5 stages
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int k = 0; k < 4; k++)
      begin
        pipe[k] <= '0;
      end
      wr_en_q <= 1'b0;
      wr_last <= 1'b0;
    end
    else
    begin
      pipe[0] <= step;
      pipe[1] <= pipe[0];
      pipe[2] <= pipe[1];
      pipe[3] <= pipe[2];
      wr_en_q <= pipe[3].valid;
      wr_last <= pipe[3].valid & (pipe[3].index[POS_W-1:1] == STEP_W'(STEPS - 1));
    end
  end

  // --------------------------------------------------
  // adder tree and reduction
  // --------------------------------------------------
  always_comb
  begin
    sum_lo = '0;
    sum_hi = '0;
    for (int k = 0; k < NUM_CORES; k++)
    begin
      sum_lo = sum_lo + SUM_W'(lanes[k].lo);
      sum_hi = sum_hi + SUM_W'(lanes[k].hi);
    end
  end

  // first pass starts from zero, the RAM holds stale data
  assign prev = pipe[2].first ? '0 : ram_q;

  always_ff @(posedge clk)
  begin
    sum_q_lo  <= sum_lo;
    sum_q_hi  <= sum_hi;
    fold_q_lo <= fold(sum_q_lo);
    fold_q_hi <= fold(sum_q_hi);
    red_q.lo  <= sub_q(fold_q_lo);
    red_q.hi  <= sub_q(fold_q_hi);
    acc_lo    <= (COEFF_W + 1)'(red_q.lo) + (COEFF_W + 1)'(prev.lo);
    acc_hi    <= (COEFF_W + 1)'(red_q.hi) + (COEFF_W + 1)'(prev.hi);
    wr_data_q <= '{hi: sub_q(acc_hi), lo: sub_q(acc_lo)};
    wr_addr_q <= pipe[3].index[POS_W-1:1];
    rd_data   <= ram_q;
  end

  // host read wins when rd_en is high
  assign ram_rd_addr = rd_en ? rd_addr : pipe[1].index[POS_W-1:1];

  sdp_ram #(
    .payload_t (coeff_pair_t),
    .DEPTH     (STEPS)
  ) i_res_ram (
    .clk     (clk),
    .wr_en   (wr_en_q),
    .wr_addr (wr_addr_q),
    .wr_data (wr_data_q),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_q)
  );

endmodule

`default_nettype wire

// File: sparse_mul_core.sv
// --------------------------------------------------
// one multiplier lane, streams a rotated copy of the
// dense polynomial with wrap and sign correction
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sparse_mul_core (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             poly_wr_en,
  input  logic [sparse_mul_pkg::POS_W-1:0] poly_wr_addr,
  input  sparse_mul_pkg::coeff_pair_t      poly_wr_data,
  input  logic                             pos_valid,
  input  logic [sparse_mul_pkg::POS_W-1:0] pos,
  input  sparse_mul_pkg::step_t            step,
  output sparse_mul_pkg::coeff_pair_t      lane_out
);
  import sparse_mul_pkg::*;

  logic [POS_W-1:0] pos_q;
  logic [POS_W-1:0] rd_addr_q;
  logic [POS_W-1:0] ram_addr;
  coeff_pair_t      ram_q;
  logic [POS_W-1:0] j_lo;
  logic [POS_W-1:0] j_hi;
  logic             keep_lo;
  logic             keep_hi;

  // start at a[(N - pos) mod N], then two coefficients per cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pos_q     <= '0;
      rd_addr_q <= '0;
    end
    else if (pos_valid)
    begin
      pos_q     <= pos;
      rd_addr_q <= POS_W'(N - int'(pos));
    end
    else
    begin
      rd_addr_q <= rd_addr_q + POS_W'(2);
    end
  end

  // host load shares the address with the lane
  assign ram_addr = poly_wr_en ? poly_wr_addr : rd_addr_q;

  sdp_ram #(
    .payload_t (coeff_pair_t),
    .DEPTH     (N)
  ) i_poly_ram (
    .clk     (clk),
    .wr_en   (poly_wr_en),
    .wr_addr (poly_wr_addr),
    .wr_data (poly_wr_data),
    .rd_addr (ram_addr),
    .rd_data (ram_q)
  );

  // output index of the word now leaving the RAM
  // the counter is already two ahead of it
  assign j_lo = rd_addr_q + pos_q - POS_W'(2);
  assign j_hi = {j_lo[POS_W-1:1], 1'b1};

  // wrapped terms pick up a -1 from x^N = -1
  assign keep_lo = (j_lo >= pos_q) == ~step.negative;
  assign keep_hi = (j_hi >= pos_q) == ~step.negative;

  always_ff @(posedge clk)
  begin
    lane_out.lo <= keep_lo ? ram_q.lo : coeff_t'(Q - int'(ram_q.lo));
    lane_out.hi <= keep_hi ? ram_q.hi : coeff_t'(Q - int'(ram_q.hi));
  end

endmodule

`default_nettype wire

// File: sparse_mul_ctrl.sv
// --------------------------------------------------
// pass and step sequencer, owns the position RAM
// and the busy/done handshake to the host
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sparse_mul_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              start,
  input  logic                              pos_wr_en,
  input  logic [sparse_mul_pkg::PASS_W-1:0] pos_wr_addr,
  input  sparse_mul_pkg::pos_word_t         pos_wr_data,
  input  logic                              wr_last,
  output logic                              busy,
  output logic                              done,
  output logic                              pos_valid,
  output sparse_mul_pkg::pos_word_t         pos_word,
  output sparse_mul_pkg::step_t             step
);
  import sparse_mul_pkg::*;

  logic              start_go;
  logic              last_pass;
  logic              fetch;
  logic              fetch_q;
  logic [PASS_W-1:0] pass;
  logic              first_pass;
  logic [1:0]        pv_d;
  logic              step_valid;
  logic [POS_W-1:0]  step_index;
  logic              negative;

  assign start_go  = start & ~busy;
  assign last_pass = (pass == PASS_W'(NUM_PASSES - 1));

  // a new pass begins on start or on the end of a pass that is not the last
  assign fetch = start_go | (busy & wr_last & ~last_pass);

  // second half of the positions carry -1
  assign negative = (int'(pass) * NUM_CORES) >= (H / 2);

  // --------------------------------------------------
  // pass bookkeeping
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy       <= 1'b0;
      done       <= 1'b0;
      pass       <= '0;
      first_pass <= 1'b0;
      fetch_q    <= 1'b0;
      pos_valid  <= 1'b0;
      pv_d       <= '0;
    end
    else
    begin
      done <= busy & wr_last & last_pass;
      if (start_go)
      begin
        busy <= 1'b1;
      end
      else if (done)
      begin
        busy <= 1'b0;
      end
      if (start_go)
      begin
        pass       <= '0;
        first_pass <= 1'b1;
      end
      else if (busy & wr_last)
      begin
        pass       <= last_pass ? pass : pass + 1'b1;
        first_pass <= 1'b0;
      end
      // one cycle to issue the read, one for the RAM
      fetch_q   <= fetch;
      pos_valid <= fetch_q;
      pv_d      <= {pv_d[0], pos_valid};
    end
  end

  // --------------------------------------------------
  // pair index, even coefficients 0 to N-2
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      step_valid <= 1'b0;
      step_index <= '0;
    end
    else if (pv_d[1])
    begin
      step_valid <= 1'b1;
      step_index <= '0;
    end
    else if (step_valid)
    begin
      if (step_index == POS_W'(N - 2))
      begin
        step_valid <= 1'b0;
      end
      step_index <= step_index + POS_W'(2);
    end
  end

  assign step = '{valid: step_valid, index: step_index, negative: negative, first: first_pass};

  // position words, read at the current pass
  sdp_ram #(
    .payload_t (pos_word_t),
    .DEPTH     (NUM_PASSES)
  ) i_pos_ram (
    .clk     (clk),
    .wr_en   (pos_wr_en),
    .wr_addr (pos_wr_addr),
    .wr_data (pos_wr_data),
    .rd_addr (pass),
    .rd_data (pos_word)
  );

endmodule

`default_nettype wire

// File: sparse_mul_pkg.sv
// --------------------------------------------------
// sparse polynomial multiplier shared definitions
// sizes, widths and the bundles passed between blocks
// --------------------------------------------------
`default_nettype none

package sparse_mul_pkg;

  // ring and modulus
  localparam int Q       = 251;
  localparam int COEFF_W = 8;
  localparam int N       = 32;
  localparam int H       = 8;

  // parallel lanes and derived counts
  localparam int NUM_CORES  = 4;
  localparam int POS_W      = $clog2(N);
  localparam int NUM_PASSES = H / NUM_CORES;
  localparam int STEPS      = N / 2;
  localparam int STEP_W     = $clog2(STEPS);
  localparam int PASS_W     = (NUM_PASSES > 1) ? $clog2(NUM_PASSES) : 1;

  // adder tree headroom for NUM_CORES terms below 256
  localparam int SUM_W = COEFF_W + 2;

  typedef logic [COEFF_W-1:0] coeff_t;

  // two neighbouring coefficients, lo is the even index
  typedef struct packed {
    coeff_t hi;
    coeff_t lo;
  } coeff_pair_t;

  // lane k takes element k
  typedef logic [NUM_CORES-1:0][POS_W-1:0] pos_word_t;

  // per-pair broadcast from the sequencer
  typedef struct packed {
    logic             valid;
    logic [POS_W-1:0] index;
    logic             negative;
    logic             first;
  } step_t;

endpackage

`default_nettype wire

// File: sparse_mul_testdata.hex
// dense words {a[i+1], a[i]} for i = 0..31, then per run 2 position words
// (lane 3 in the top bits) and 16 expected result words {c[2i+1], c[2i]}
// dense polynomial, a[i] = 200 + i
C9C8
CAC9
CBCA
CCCB
CDCC
CECD
CFCE
D0CF
D1D0
D2D1
D3D2
D4D3
D5D4
D6D5
D7D6
D8D7
D9D8
DAD9
DBDA
DCDB
DDDC
DEDD
DFDE
E0DF
E1E0
E2E1
E3E2
E4E3
E5E4
E6E5
E7E6
C8E7
// run 1, +1 at 7 26 0 19, -1 at 31 3 22 12
98347
6587F
A7A5
F1A9
F1F1
ABF1
AFAD
B3B1
0000
0000
0000
B500
B9B7
0606
0606
BDBB
C1BF
10C3
// run 2, +1 at 15 1 30 10, -1 at 8 29 5 21
5782F
A97A8
AEF4
B2B0
01B4
0101
4547
F8F8
F8F8
B2F8
B6B4
BAB8
09BC
0909
0909
0909
4F09
0707

// File: sparse_mul_top.sv
// --------------------------------------------------
// sparse polynomial multiplier top level
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sparse_mul_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              start,
  input  logic                              poly_wr_en,
  input  logic [sparse_mul_pkg::POS_W-1:0]  poly_wr_addr,
  input  sparse_mul_pkg::coeff_pair_t       poly_wr_data,
  input  logic                              pos_wr_en,
  input  logic [sparse_mul_pkg::PASS_W-1:0] pos_wr_addr,
  input  sparse_mul_pkg::pos_word_t         pos_wr_data,
  input  logic                              rd_en,
  input  logic [sparse_mul_pkg::STEP_W-1:0] rd_addr,
  output logic                              busy,
  output logic                              done,
  output sparse_mul_pkg::coeff_pair_t       rd_data
);
  import sparse_mul_pkg::*;

  logic        pos_valid;
  pos_word_t   pos_word;
  step_t       step;
  logic        wr_last;
  coeff_pair_t lanes [NUM_CORES];

  sparse_mul_ctrl i_ctrl (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .pos_wr_en   (pos_wr_en),
    .pos_wr_addr (pos_wr_addr),
    .pos_wr_data (pos_wr_data),
    .wr_last     (wr_last),
    .busy        (busy),
    .done        (done),
    .pos_valid   (pos_valid),
    .pos_word    (pos_word),
    .step        (step)
  );

  // one lane per position in a pass
  for (genvar k = 0; k < NUM_CORES; k++)
  begin : g_core
    sparse_mul_core i_core (
      .clk          (clk),
      .rst          (rst),
      .poly_wr_en   (poly_wr_en),
      .poly_wr_addr (poly_wr_addr),
      .poly_wr_data (poly_wr_data),
      .pos_valid    (pos_valid),
      .pos          (pos_word[k]),
      .step         (step),
      .lane_out     (lanes[k])
    );
  end

  sparse_mul_accum i_accum (
    .clk     (clk),
    .rst     (rst),
    .step    (step),
    .lanes   (lanes),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .wr_last (wr_last),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: tb_sparse_mul.sv
// --------------------------------------------------
// self-checking testbench for the sparse polynomial
// multiplier, stimulus and results from a hex file
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_sparse_mul;
  import sparse_mul_pkg::*;

  localparam int RUNS       = 2;
  localparam int WORD_W     = NUM_CORES * POS_W;
  localparam int RUN_WORDS  = NUM_PASSES + STEPS;
  localparam int DATA_WORDS = N + RUNS * RUN_WORDS;
  localparam int MAX_CYCLES = 4 * (RUNS * NUM_PASSES * (STEPS + 12) + 100);

  logic              clk;
  logic              rst;
  logic              start;
  logic              poly_wr_en;
  logic [POS_W-1:0]  poly_wr_addr;
  coeff_pair_t       poly_wr_data;
  logic              pos_wr_en;
  logic [PASS_W-1:0] pos_wr_addr;
  pos_word_t         pos_wr_data;
  logic              rd_en;
  logic [STEP_W-1:0] rd_addr;
  logic              busy;
  logic              done;
  coeff_pair_t       rd_data;

  // dense words, then per run the position words and expected pairs
  logic [WORD_W-1:0] tdata [DATA_WORDS];

  int mismatches = 0;
  int failures   = 0;
  int cycles     = 0;

  sparse_mul_top i_sparse_mul_top (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .poly_wr_en   (poly_wr_en),
    .poly_wr_addr (poly_wr_addr),
    .poly_wr_data (poly_wr_data),
    .pos_wr_en    (pos_wr_en),
    .pos_wr_addr  (pos_wr_addr),
    .pos_wr_data  (pos_wr_data),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .busy         (busy),
    .done         (done),
    .rd_data      (rd_data)
  );

  initial
  begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  // run limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, the run never finished", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // host side tasks
  // --------------------------------------------------
  task automatic load_dense();
    for (int i = 0; i < N; i++)
    begin
      @(posedge clk);
      #1;
      poly_wr_en   = 1'b1;
      poly_wr_addr = POS_W'(i);
      poly_wr_data = coeff_pair_t'(tdata[i][15:0]);
    end
    @(posedge clk);
    #1;
    poly_wr_en = 1'b0;
  endtask

  task automatic load_positions(input int run);
    for (int w = 0; w < NUM_PASSES; w++)
    begin
      @(posedge clk);
      #1;
      pos_wr_en   = 1'b1;
      pos_wr_addr = PASS_W'(w);
      pos_wr_data = pos_word_t'(tdata[N + run * RUN_WORDS + w]);
    end
    @(posedge clk);
    #1;
    pos_wr_en = 1'b0;
  endtask

  // pulse start, follow busy and count done pulses
  task automatic run_once(input bit extra_start);
    int waited;
    int done_count;
    waited     = 0;
    done_count = 0;
    @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (busy !== 1'b1)
    begin
      $display("busy did not rise on the cycle after start");
      failures++;
    end
    while (done !== 1'b1)
    begin
      if (busy !== 1'b1)
      begin
        $display("busy dropped before done at wait cycle %0d", waited);
        failures++;
      end
      // a start in the middle of the run must be ignored
      start = extra_start && (waited == STEPS);
      @(posedge clk);
      #1;
      waited++;
    end
    start = 1'b0;
    done_count++;
    if (busy !== 1'b1)
    begin
      $display("busy was already low while done was high");
      failures++;
    end
    for (int c = 0; c < NUM_PASSES * (STEPS + 12); c++)
    begin
      @(posedge clk);
      #1;
      if (done === 1'b1)
      begin
        done_count++;
      end
      if (busy !== 1'b0)
      begin
        $display("busy still high %0d cycles after done", c + 1);
        failures++;
      end
    end
    if (done_count != 1)
    begin
      $display("done pulsed %0d times in one run", done_count);
      failures++;
    end
  endtask

  // rd_data follows rd_en by two cycles
  task automatic read_pair(input logic [STEP_W-1:0] addr, output coeff_pair_t data);
    @(posedge clk);
    #1;
    rd_en   = 1'b1;
    rd_addr = addr;
    @(posedge clk);
    #1;
    rd_en = 1'b0;
    @(posedge clk);
    #1;
    data = rd_data;
  endtask

  task automatic check_results(input int run);
    int          base;
    coeff_pair_t expected;
    coeff_pair_t got;
    base = N + run * RUN_WORDS + NUM_PASSES;
    for (int i = 0; i < STEPS; i++)
    begin
      expected = coeff_pair_t'(tdata[base + i][15:0]);
      read_pair(STEP_W'(i), got);
      if (got !== expected)
      begin
        $display("mismatch rd_data run %0d word %0d: got %h expected %h",
                 run, i, got, expected);
        mismatches++;
      end
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    rst          = 1'b1;
    start        = 1'b0;
    poly_wr_en   = 1'b0;
    poly_wr_addr = '0;
    poly_wr_data = '0;
    pos_wr_en    = 1'b0;
    pos_wr_addr  = '0;
    pos_wr_data  = '0;
    rd_en        = 1'b0;
    rd_addr      = '0;
    $readmemh("sparse_mul_testdata.hex", tdata);
    if ($isunknown(tdata[DATA_WORDS-1]))
    begin
      $display("test data file is missing or too short");
      failures++;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // idle after reset
    for (int c = 0; c < 3; c++)
    begin
      if (busy !== 1'b0 || done !== 1'b0)
      begin
        $display("busy or done not low after reset");
        failures++;
      end
      @(posedge clk);
      #1;
    end

    load_dense();
    for (int r = 0; r < RUNS; r++)
    begin
      load_positions(r);
      run_once(r == 1);
      check_results(r);
    end

    $display("%0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
